//--- cpuPkg.sv
package cpuPkg;

    // sequence numbers wrap; age is the sign of a difference.
    localparam int DEF_SQN_BITS = 6;

    // depth must be a power of two, at most 32.
    localparam int DEF_LB_ENTRIES = 8;

    typedef logic [DEF_SQN_BITS-1:0] SqN;

    // address bits 31 to 2.
    typedef logic [29:0] WordAddr;

    typedef struct packed {
        logic valid;
        SqN sqN;
        WordAddr addr;
    } LbEntry;

    // word part of a byte address.
    function automatic WordAddr wordOf(input logic [31:0] byteAddr);
        return byteAddr[31:2];
    endfunction

endpackage

//--- memOpIf.sv
interface memOpIf;
    import cpuPkg::*;

    logic valid;
    logic isLoad;
    logic [31:0] pc;
    logic [31:0] addr;
    SqN sqN;
    SqN loadSqN;
    SqN storeSqN;

    // one strobe per operation, no ready.
    modport source (
        output valid,
        output isLoad,
        output pc,
        output addr,
        output sqN,
        output loadSqN,
        output storeSqN
    );

    modport sink (
        input valid,
        input isLoad,
        input pc,
        input addr,
        input sqN,
        input loadSqN,
        input storeSqN
    );

endinterface

//--- branchIf.sv
interface branchIf;
    import cpuPkg::*;

    logic taken;
    logic [31:0] dstPc;
    SqN sqN;
    SqN loadSqN;
    SqN storeSqN;
    logic flush;

    modport source (
        output taken,
        output dstPc,
        output sqN,
        output loadSqN,
        output storeSqN,
        output flush
    );

    modport sink (
        input taken,
        input dstPc,
        input sqN,
        input loadSqN,
        input storeSqN,
        input flush
    );

endinterface

//--- memIssueStage.sv
module memIssueStage #(
    parameter int SQN_BITS = cpuPkg::DEF_SQN_BITS
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  logic inIsLoad,
    input  logic [31:0] inPc,
    input  logic [31:0] inAddr,
    input  cpuPkg::SqN inSqN,
    input  cpuPkg::SqN inLoadSqN,
    input  cpuPkg::SqN inStoreSqN,
    input  cpuPkg::SqN maxLoadSqN,
    branchIf.sink brIf,
    output logic stall,
    memOpIf.source op
);
    import cpuPkg::*;

    logic holdValid;
    logic [31:0] holdPc;
    logic [31:0] holdAddr;
    SqN holdSqN;
    SqN holdLoadSqN;
    SqN holdStoreSqN;

    logic signed [SQN_BITS-1:0] inAhead;
    logic signed [SQN_BITS-1:0] holdAhead;
    logic signed [SQN_BITS-1:0] holdAge;

    logic accept;
    logic inOutside;
    logic holdFits;
    logic holdSquashed;

    // positive means beyond the load window.
    assign inAhead = inLoadSqN - maxLoadSqN;
    assign holdAhead = holdLoadSqN - maxLoadSqN;
    assign holdAge = holdSqN - brIf.sqN;

    assign accept = inValid && !holdValid;
    assign inOutside = inIsLoad && (inAhead > 0);
    assign holdFits = holdAhead <= 0;
    assign holdSquashed = brIf.taken && (holdAge > 0);

    assign stall = holdValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            holdValid <= 1'b0;
            op.valid <= 1'b0;
        end else begin
            op.valid <= 1'b0;
            if (holdValid) begin
                if (holdSquashed) begin
                    holdValid <= 1'b0;
                end else if (holdFits) begin
                    holdValid <= 1'b0;
                    op.valid <= 1'b1;
                end
            end else if (accept) begin
                if (inOutside) begin
                    holdValid <= 1'b1;
                end else begin
                    op.valid <= 1'b1;
                end
            end
        end
    end

    // hold register follows the input until it is armed.
    always_ff @(posedge clk) begin
        if (!holdValid) begin
            holdPc <= inPc;
            holdAddr <= inAddr;
            holdSqN <= inSqN;
            holdLoadSqN <= inLoadSqN;
            holdStoreSqN <= inStoreSqN;
        end
    end

    always_ff @(posedge clk) begin
        if (holdValid) begin
            op.isLoad <= 1'b1;
            op.pc <= holdPc;
            op.addr <= holdAddr;
            op.sqN <= holdSqN;
            op.loadSqN <= holdLoadSqN;
            op.storeSqN <= holdStoreSqN;
        end else begin
            op.isLoad <= inIsLoad;
            op.pc <= inPc;
            op.addr <= inAddr;
            op.sqN <= inSqN;
            op.loadSqN <= inLoadSqN;
            op.storeSqN <= inStoreSqN;
        end
    end

endmodule

//--- loadBuffer.sv
module loadBuffer #(
    parameter int NUM_ENTRIES = cpuPkg::DEF_LB_ENTRIES,
    parameter int SQN_BITS = cpuPkg::DEF_SQN_BITS
) (
    input  logic clk,
    input  logic rst,
    input  cpuPkg::SqN commitSqN,
    memOpIf.sink op,
    branchIf.sink brIf,
    branchIf.source viol,
    output cpuPkg::SqN maxLoadSqN
);
    import cpuPkg::*;

    localparam int IDX_BITS = $clog2(NUM_ENTRIES);

    LbEntry entries [NUM_ENTRIES];
    SqN base;
    SqN baseNext;

    // staged operation, one cycle behind the memory op bus.
    logic sValid;
    logic sIsLoad;
    logic [31:0] sPc;
    WordAddr sWord;
    SqN sSqN;
    SqN sLoadSqN;
    SqN sStoreSqN;

    logic signed [SQN_BITS-1:0] inAge;
    logic signed [SQN_BITS-1:0] sAge;
    logic signed [SQN_BITS-1:0] commitAge;
    logic signed [SQN_BITS-1:0] entryAge [NUM_ENTRIES];
    logic signed [SQN_BITS-1:0] storeAge [NUM_ENTRIES];

    logic sLive;
    logic loadIn;
    logic storeIn;
    logic retire;
    logic orderHit;
    logic [IDX_BITS-1:0] insIdx;

    assign inAge = op.sqN - brIf.sqN;
    assign sAge = sSqN - brIf.sqN;
    assign commitAge = commitSqN - entries[0].sqN;

    assign sLive = sValid && !(brIf.taken && (sAge > 0));
    assign loadIn = sLive && sIsLoad;
    assign storeIn = sLive && !sIsLoad;
    assign retire = !brIf.taken && entries[0].valid && (commitAge > 0);

    always_comb begin
        baseNext = base;
        if (brIf.taken) begin
            if (brIf.flush) begin
                baseNext = brIf.loadSqN;
            end
        end else if (retire) begin
            baseNext = base + SqN'(1);
        end
    end

    // slot is relative to the base after this edge's retirement.
    assign insIdx = sLoadSqN[IDX_BITS-1:0] - baseNext[IDX_BITS-1:0];

    // a squashed entry cannot cause a violation.
    always_comb begin
        orderHit = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            entryAge[i] = entries[i].sqN - brIf.sqN;
            storeAge[i] = sSqN - entries[i].sqN;
            if (entries[i].valid && entries[i].addr == sWord && storeAge[i] <= 0 &&
                !(brIf.taken && entryAge[i] > 0)) begin
                orderHit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sValid <= 1'b0;
        end else begin
            sValid <= op.valid && !(brIf.taken && (inAge > 0));
        end
    end

    always_ff @(posedge clk) begin
        sIsLoad <= op.isLoad;
        sPc <= op.pc;
        sWord <= wordOf(op.addr);
        sSqN <= op.sqN;
        sLoadSqN <= op.loadSqN;
        sStoreSqN <= op.storeSqN;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
            base <= '0;
            maxLoadSqN <= SqN'(NUM_ENTRIES - 1);
            viol.taken <= 1'b0;
        end else begin
            if (brIf.taken) begin
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    if (entryAge[i] > 0) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end else if (retire) begin
                for (int i = 0; i < NUM_ENTRIES - 1; i++) begin
                    entries[i] <= entries[i + 1];
                end
                entries[NUM_ENTRIES - 1].valid <= 1'b0;
            end
            if (loadIn) begin
                entries[insIdx] <= '{valid: 1'b1, sqN: sSqN, addr: sWord};
            end
            base <= baseNext;
            maxLoadSqN <= baseNext + SqN'(NUM_ENTRIES - 1);
            viol.taken <= storeIn && orderHit;
        end
    end

    // refetch from the store that ran too late.
    always_ff @(posedge clk) begin
        viol.dstPc <= sPc;
        viol.sqN <= sSqN;
        viol.loadSqN <= sLoadSqN;
        viol.storeSqN <= sStoreSqN;
    end

    assign viol.flush = 1'b0;

endmodule

//--- branchArbiter.sv
module branchArbiter #(
    parameter int SQN_BITS = cpuPkg::DEF_SQN_BITS
) (
    input  logic clk,
    input  logic rst,
    input  logic exTaken,
    input  logic [31:0] exDstPc,
    input  cpuPkg::SqN exSqN,
    input  cpuPkg::SqN exLoadSqN,
    input  cpuPkg::SqN exStoreSqN,
    input  logic exFlush,
    branchIf.sink viol,
    branchIf.source br
);

    logic signed [SQN_BITS-1:0] exVsBr;
    logic signed [SQN_BITS-1:0] violVsBr;
    logic signed [SQN_BITS-1:0] exVsViol;

    logic exLive;
    logic violLive;
    logic pickViol;

    assign exVsBr = exSqN - br.sqN;
    assign violVsBr = viol.sqN - br.sqN;
    assign exVsViol = exSqN - viol.sqN;

    // requests behind the current branch are on the squashed path.
    assign exLive = exTaken && !(br.taken && (exVsBr > 0));
    assign violLive = viol.taken && !(br.taken && (violVsBr > 0));

    // execute branch wins a tie.
    assign pickViol = violLive && (!exLive || (exVsViol > 0));

    always_ff @(posedge clk) begin
        if (rst) begin
            br.taken <= 1'b0;
        end else begin
            br.taken <= exLive || violLive;
        end
    end

    always_ff @(posedge clk) begin
        if (pickViol) begin
            br.dstPc <= viol.dstPc;
            br.sqN <= viol.sqN;
            br.loadSqN <= viol.loadSqN;
            br.storeSqN <= viol.storeSqN;
            br.flush <= viol.flush;
        end else begin
            br.dstPc <= exDstPc;
            br.sqN <= exSqN;
            br.loadSqN <= exLoadSqN;
            br.storeSqN <= exStoreSqN;
            br.flush <= exFlush;
        end
    end

endmodule

//--- memOrderCore.sv
module memOrderCore #(
    parameter int NUM_ENTRIES = cpuPkg::DEF_LB_ENTRIES,
    parameter int SQN_BITS = cpuPkg::DEF_SQN_BITS
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  logic inIsLoad,
    input  logic [31:0] inPc,
    input  logic [31:0] inAddr,
    input  cpuPkg::SqN inSqN,
    input  cpuPkg::SqN inLoadSqN,
    input  cpuPkg::SqN inStoreSqN,
    input  cpuPkg::SqN commitSqN,
    input  logic exTaken,
    input  logic [31:0] exDstPc,
    input  cpuPkg::SqN exSqN,
    input  cpuPkg::SqN exLoadSqN,
    input  cpuPkg::SqN exStoreSqN,
    input  logic exFlush,
    output logic stall,
    output logic brTaken,
    output logic [31:0] brDstPc,
    output cpuPkg::SqN brSqN,
    output cpuPkg::SqN brLoadSqN,
    output cpuPkg::SqN brStoreSqN,
    output logic brFlush,
    output cpuPkg::SqN maxLoadSqN
);

    memOpIf opIf ();
    branchIf violIf ();
    branchIf brIf ();

    memIssueStage #(
        .SQN_BITS(SQN_BITS)
    ) u_memIssueStage (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inIsLoad(inIsLoad),
        .inPc(inPc),
        .inAddr(inAddr),
        .inSqN(inSqN),
        .inLoadSqN(inLoadSqN),
        .inStoreSqN(inStoreSqN),
        .maxLoadSqN(maxLoadSqN),
        .brIf(brIf.sink),
        .stall(stall),
        .op(opIf.source)
    );

    loadBuffer #(
        .NUM_ENTRIES(NUM_ENTRIES),
        .SQN_BITS(SQN_BITS)
    ) u_loadBuffer (
        .clk(clk),
        .rst(rst),
        .commitSqN(commitSqN),
        .op(opIf.sink),
        .brIf(brIf.sink),
        .viol(violIf.source),
        .maxLoadSqN(maxLoadSqN)
    );

    branchArbiter #(
        .SQN_BITS(SQN_BITS)
    ) u_branchArbiter (
        .clk(clk),
        .rst(rst),
        .exTaken(exTaken),
        .exDstPc(exDstPc),
        .exSqN(exSqN),
        .exLoadSqN(exLoadSqN),
        .exStoreSqN(exStoreSqN),
        .exFlush(exFlush),
        .viol(violIf.sink),
        .br(brIf.source)
    );

    assign brTaken = brIf.taken;
    assign brDstPc = brIf.dstPc;
    assign brSqN = brIf.sqN;
    assign brLoadSqN = brIf.loadSqN;
    assign brStoreSqN = brIf.storeSqN;
    assign brFlush = brIf.flush;

endmodule

//--- memOrderProps.sv
module memOrderProps (
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic inIsLoad,
    input cpuPkg::SqN inLoadSqN,
    input logic stall,
    input cpuPkg::SqN maxLoadSqN,
    input logic exTaken,
    input cpuPkg::SqN exSqN,
    input logic brTaken,
    input cpuPkg::SqN brSqN,
    input cpuPkg::SqN brLoadSqN,
    input logic brFlush
);
    import cpuPkg::*;

    int failCount = 0;

    resetState: assert property (@(posedge clk)
        rst |=> !stall && !brTaken && maxLoadSqN == SqN'(DEF_LB_ENTRIES - 1))
        else begin
            failCount++;
            $error("ERROR %0t: state after reset is wrong", $time);
        end

    // a load beyond the window is held.
    stallOnOutside: assert property (@(posedge clk) disable iff (rst)
        inValid && !stall && inIsLoad && $signed(SqN'(inLoadSqN - maxLoadSqN)) > 0 |=> stall)
        else begin
            failCount++;
            $error("ERROR %0t: no stall for out-of-window load", $time);
        end

    windowStep: assert property (@(posedge clk) disable iff (rst)
        !(brTaken && brFlush) |=> SqN'(maxLoadSqN - $past(maxLoadSqN)) <= SqN'(1))
        else begin
            failCount++;
            $error("ERROR %0t: load window moved by more than one", $time);
        end

    flushWindow: assert property (@(posedge clk) disable iff (rst)
        brTaken && brFlush |=> maxLoadSqN == SqN'($past(brLoadSqN) + DEF_LB_ENTRIES - 1))
        else begin
            failCount++;
            $error("ERROR %0t: window not rebased by flush", $time);
        end

    // the branch shown is the external one or an older one.
    exLatency: assert property (@(posedge clk) disable iff (rst)
        exTaken && !brTaken |=> brTaken && $signed(SqN'(brSqN - $past(exSqN))) <= 0)
        else begin
            failCount++;
            $error("ERROR %0t: external branch not forwarded", $time);
        end

endmodule

bind memOrderCore memOrderProps u_props (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inIsLoad(inIsLoad),
    .inLoadSqN(inLoadSqN),
    .stall(stall),
    .maxLoadSqN(maxLoadSqN),
    .exTaken(exTaken),
    .exSqN(exSqN),
    .brTaken(brTaken),
    .brSqN(brSqN),
    .brLoadSqN(brLoadSqN),
    .brFlush(brFlush)
);

//--- memOrderTb.sv
module memOrderTb;
    import cpuPkg::*;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic inValid = 1'b0;
    logic inIsLoad = 1'b0;
    logic [31:0] inPc = '0;
    logic [31:0] inAddr = '0;
    SqN inSqN = '0;
    SqN inLoadSqN = '0;
    SqN inStoreSqN = '0;
    SqN commitSqN = '0;
    logic exTaken = 1'b0;
    logic [31:0] exDstPc = '0;
    SqN exSqN = '0;
    SqN exLoadSqN = '0;
    SqN exStoreSqN = '0;
    logic exFlush = 1'b0;
    logic stall;
    logic brTaken;
    logic [31:0] brDstPc;
    SqN brSqN;
    SqN brLoadSqN;
    SqN brStoreSqN;
    logic brFlush;
    SqN maxLoadSqN;

    int seed = 87698;
    int tbErrors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int errMark;
    int cycles;
    logic [31:0] addrA;
    logic [31:0] addrB;

    memOrderCore u_memOrderCore (.*);

    always #10 clk = ~clk;

    function automatic int totalErrors();
        return tbErrors + u_memOrderCore.u_props.failCount;
    endfunction

    function automatic logic [31:0] randomWord();
        return $random(seed) & 32'hffff_fffc;
    endfunction

    task automatic verify(input bit cond, input string msg);
        assert (cond) else begin
            tbErrors++;
            $display("ERROR %0t: %s", $time, msg);
        end
    endtask

    task automatic startTest();
        errMark = totalErrors();
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (totalErrors() == errMark) begin
            $display("test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed", testsRun, name);
        end
    endtask

    // called on a falling edge; returns on the next falling edge.
    task automatic issue(input bit isLoad, input logic [31:0] pc, input logic [31:0] addr,
                         input SqN sq, input SqN lsq, input SqN ssq);
        inValid = 1'b1;
        inIsLoad = isLoad;
        inPc = pc;
        inAddr = addr;
        inSqN = sq;
        inLoadSqN = lsq;
        inStoreSqN = ssq;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    task automatic waitBr(input int limit, output int n);
        n = 0;
        while (!brTaken && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!brTaken) begin
            tbErrors++;
            $display("timeout: no branch seen within %0d cycles", limit);
        end
    endtask

    task automatic expectNoBr(input int n);
        repeat (n) begin
            @(negedge clk);
            verify(!brTaken, "unexpected branch");
        end
    endtask

    // external branch lands in the same cycle as a violation.
    task automatic arbCase(input SqN ldSq, input SqN stSq, input SqN brSq, input bit violWins);
        addrA = randomWord();
        issue(1'b1, 32'h0000_0500, addrA, ldSq, 6'd6, 6'd3);
        issue(1'b0, 32'h0000_0600, addrA, stSq, 6'd6, 6'd3);
        repeat (2) @(negedge clk);
        exTaken = 1'b1;
        exDstPc = 32'h0000_0300;
        exSqN = brSq;
        exLoadSqN = 6'd6;
        exStoreSqN = 6'd3;
        @(negedge clk);
        exTaken = 1'b0;
        verify(brTaken, "arbitrated branch not taken");
        verify(brSqN == (violWins ? stSq : brSq), "arbiter picked wrong sqN");
        verify(brDstPc == (violWins ? 32'h0000_0600 : 32'h0000_0300), "arbiter wrong pc");
        repeat (3) @(negedge clk);
    endtask

    initial begin
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        startTest();
        addrA = randomWord();
        issue(1'b1, 32'h0000_0050, addrA, 6'd5, 6'd1, 6'd3);
        issue(1'b0, 32'h0000_0100, addrA, 6'd3, 6'd1, 6'd2);
        waitBr(10, cycles);
        verify(cycles == 3, "violation branch latency is not 3 cycles");
        verify(brDstPc == 32'h0000_0100 && brSqN == 6'd3, "violation carries wrong pc or sqN");
        verify(brLoadSqN == 6'd1 && brStoreSqN == 6'd2 && !brFlush, "violation fields wrong");
        repeat (2) @(negedge clk);
        endTest("order violation");

        startTest();
        addrB = randomWord();
        issue(1'b1, 32'h0000_0054, addrB, 6'd5, 6'd0, 6'd0);
        issue(1'b0, 32'h0000_0110, addrB ^ 32'h4, 6'd4, 6'd0, 6'd0);
        expectNoBr(6);
        issue(1'b0, 32'h0000_0120, addrB, 6'd7, 6'd1, 6'd1);
        expectNoBr(6);
        endTest("no false violation");

        startTest();
        issue(1'b1, 32'h0000_0060, randomWord(), 6'd8, 6'd1, 6'd1);
        issue(1'b1, 32'h0000_0064, randomWord(), 6'd9, 6'd2, 6'd1);
        issue(1'b1, 32'h0000_0068, randomWord(), 6'd10, 6'd3, 6'd1);
        @(negedge clk);
        verify(maxLoadSqN == 6'd7, "window moved before commit");
        commitSqN = 6'd11;
        cycles = 0;
        while (maxLoadSqN != 6'd11 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        verify(cycles == 4, "retirement did not advance one entry per cycle");
        repeat (4) @(negedge clk);
        verify(maxLoadSqN == 6'd11, "window moved past the retired loads");
        endTest("commit retirement");

        startTest();
        addrB = randomWord();
        issue(1'b1, 32'h0000_0070, randomWord(), 6'd13, 6'd4, 6'd1);
        issue(1'b1, 32'h0000_0074, addrB, 6'd20, 6'd12, 6'd2);
        verify(stall, "stall did not rise for out-of-window load");
        repeat (3) @(negedge clk);
        verify(stall, "stall dropped before the window moved");
        commitSqN = 6'd14;
        cycles = 0;
        while (stall && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            tbErrors++;
            $display("timeout: stall never dropped after commit");
        end
        repeat (3) @(negedge clk);
        issue(1'b0, 32'h0000_0180, addrB, 6'd18, 6'd12, 6'd2);
        waitBr(10, cycles);
        verify(cycles == 3 && brSqN == 6'd18, "held load missing from the buffer");
        repeat (2) @(negedge clk);
        endTest("back-pressure");

        startTest();
        addrA = randomWord();
        issue(1'b1, 32'h0000_0080, addrA, 6'd24, 6'd6, 6'd3);
        @(negedge clk);
        exTaken = 1'b1;
        exFlush = 1'b1;
        exDstPc = 32'h0000_0200;
        exSqN = 6'd21;
        exLoadSqN = 6'd6;
        exStoreSqN = 6'd3;
        @(negedge clk);
        exTaken = 1'b0;
        exFlush = 1'b0;
        verify(brTaken && brFlush && brSqN == 6'd21, "flush not on br ports");
        verify(brDstPc == 32'h0000_0200 && brLoadSqN == 6'd6, "flush fields wrong");
        @(negedge clk);
        verify(maxLoadSqN == 6'd13, "window not rebased after flush");
        issue(1'b0, 32'h0000_0190, addrA, 6'd23, 6'd6, 6'd3);
        expectNoBr(8);
        endTest("external flush");

        startTest();
        arbCase(6'd30, 6'd28, 6'd29, 1'b1);
        arbCase(6'd33, 6'd31, 6'd31, 1'b0);
        arbCase(6'd38, 6'd36, 6'd35, 1'b0);
        endTest("arbitration");

        $display("%0d tests run, %0d failed, %0d check errors",
                 testsRun, testsFailed, totalErrors());
        if (totalErrors() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("simulation did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb.f
cpuPkg.sv
memOpIf.sv
branchIf.sv
memIssueStage.sv
loadBuffer.sv
branchArbiter.sv
memOrderCore.sv
memOrderProps.sv
memOrderTb.sv

//--- runSim.sh
#!/bin/sh
# builds and runs the memory ordering testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module memOrderTb -f tb.f -o VmemOrderTb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VmemOrderTb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
